// ==== lsu.f ====
hw/lsu_pkg.sv
hw/lsu_request_gen.sv
hw/lsu_ctrl_fifo.sv
hw/lsu_rdata_align.sv
hw/lsu_top.sv
sim/lsu_bus_responder.sv
sim/lsu_properties.sv
sim/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= lsu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit 0
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  import lsu_pkg::*;

  localparam int NUM_REQ = 400;

  logic      clk;
  logic      rst_n;
  logic      core_req_valid_i;
  lsu_req_t  core_req_i;
  logic      core_req_ready_o;
  logic      bus_req_valid_o;
  bus_req_t  bus_req_o;
  logic      bus_gnt;
  logic      bus_rvalid;
  bus_resp_t bus_resp;
  logic      core_resp_valid_o;
  lsu_resp_t core_resp_o;

  integer    seed;
  int        errors;
  int        outstanding;
  logic      part_q;         // Second part of a split is next
  logic [7:0] shadow [256];
  // Expected load value and bus part count per accepted request
  logic [31:0] exp_rdata_q [$];
  int          exp_parts_q [$];

  lsu_top UUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_i        (core_req_i),
    .core_req_ready_o  (core_req_ready_o),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .bus_gnt_i         (bus_gnt),
    .bus_rvalid_i      (bus_rvalid),
    .bus_resp_i        (bus_resp),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o)
  );

  lsu_bus_responder u_bus (
    .clk             (clk),
    .rst_n           (rst_n),
    .bus_req_valid_i (bus_req_valid_o),
    .bus_req_i       (bus_req_o),
    .bus_gnt_o       (bus_gnt),
    .bus_rvalid_o    (bus_rvalid),
    .bus_resp_o      (bus_resp)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Crosses a word boundary
  function automatic logic crosses_word(input lsu_size_e size, input logic [1:0] off);
    int n;
    n = (size == LSU_SIZE_BYTE) ? 1 : (size == LSU_SIZE_HALF) ? 2 : 4;
    return (int'(off) + n) > 4;
  endfunction

  // Load result or store effect on the shadow bytes
  function automatic logic [31:0] apply_request(input lsu_req_t req);
    logic [31:0] v;
    int          n;
    int          a;
    n = (req.size == LSU_SIZE_BYTE) ? 1 : (req.size == LSU_SIZE_HALF) ? 2 : 4;
    a = int'(req.addr[7:0]);
    v = '0;
    for (int k = 0; k < n; k++) begin
      if (req.we) shadow[a + k] = req.wdata[8*k +: 8];
      else v[8*k +: 8] = shadow[a + k];
    end
    if (req.sext && req.size == LSU_SIZE_BYTE && v[7]) v[31:8] = '1;
    if (req.sext && req.size == LSU_SIZE_HALF && v[15]) v[31:16] = '1;
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Monitor at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    logic [7:0]  be8;
    logic [31:0] w;
    logic [1:0]  off;
    logic        err;
    logic [31:0] exp_rdata;
    int          parts;
    if (rst_n) begin
      // Full means no new request unless a slot frees now
      if (outstanding == 2 && !bus_rvalid) check("bus_req_valid_o", 32'(bus_req_valid_o), 32'h0);
      if (bus_req_valid_o && bus_gnt) begin
        off = core_req_i.addr[1:0];
        be8 = (core_req_i.size == LSU_SIZE_BYTE) ? 8'h01 :
              (core_req_i.size == LSU_SIZE_HALF) ? 8'h03 : 8'h0f;
        be8 = be8 << off;
        w = core_req_i.wdata;
        if (off != 2'b00) w = (w << (8 * int'(off))) | (w >> (32 - 8 * int'(off)));
        check("bus_req_o.addr", bus_req_o.addr,
              {core_req_i.addr[31:2], 2'b00} + (part_q ? 32'd4 : 32'd0));
        check("bus_req_o.we", 32'(bus_req_o.we), 32'(core_req_i.we));
        check("bus_req_o.be", 32'(bus_req_o.be), 32'(part_q ? be8[7:4] : be8[3:0]));
        if (core_req_i.we) check("bus_req_o.wdata", bus_req_o.wdata, w);
        part_q = crosses_word(core_req_i.size, off) && !part_q;
        outstanding++;
      end
      if (bus_rvalid) outstanding--;
      if (outstanding > 2) begin
        errors++;
        $display("More than two bus transactions outstanding");
      end
      // Acceptance on the last grant
      if (core_req_ready_o) begin
        exp_rdata_q.push_back(apply_request(core_req_i));
        exp_parts_q.push_back(crosses_word(core_req_i.size, core_req_i.addr[1:0]) ? 2 : 1);
      end
      // All parts were granted in earlier cycles, so their errors are logged
      if (core_resp_valid_o) begin
        if (exp_rdata_q.size() == 0) begin
          errors++;
          $display("Core response arrived with no request pending");
        end else begin
          exp_rdata = exp_rdata_q.pop_front();
          parts = exp_parts_q.pop_front();
          err = 1'b0;
          for (int p = 0; p < parts; p++) begin
            err = err | u_bus.err_log.pop_front();
          end
          check("core_resp_o.rdata", core_resp_o.rdata, exp_rdata);
          check("core_resp_o.err", 32'(core_resp_o.err), 32'(err));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic        got;
    clk = 1'b0;
    rst_n = 1'b0;
    core_req_valid_i = 1'b0;
    core_req_i = '0;
    seed = 32'hbe7;
    errors = 0;
    outstanding = 0;
    part_q = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < 64; i++) begin
      for (int b = 0; b < 4; b++) shadow[4*i + b] = u_bus.mem[i][8*b +: 8];
    end
    // Quiet outputs before the first request
    @(negedge clk);
    check("core_req_ready_o", 32'(core_req_ready_o), 32'h0);
    check("bus_req_valid_o", 32'(bus_req_valid_o), 32'h0);
    check("core_resp_valid_o", 32'(core_resp_valid_o), 32'h0);
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_REQ; n++) begin
      r = $random(seed);
      repeat (int'(r[1:0]) % 3) begin
        @(posedge clk);
        #1;
      end
      r = $random(seed);
      core_req_i.size  = lsu_size_e'((r[1:0] == 2'b11) ? 2'b10 : r[1:0]);
      // Word index up to 62 keeps the second part inside memory
      core_req_i.addr  = {24'h0, 6'(r[9:4] % 63), r[3:2]};
      core_req_i.we    = r[12];
      core_req_i.sext  = r[13];
      core_req_i.wdata = $random(seed);
      core_req_valid_i = 1'b1;
      do begin
        @(negedge clk);
        got = core_req_ready_o;
        @(posedge clk);
        #1;
      end while (!got);
      core_req_valid_i = 1'b0;
    end
    while (exp_rdata_q.size() != 0 || outstanding != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per request
  initial begin
    #(NUM_REQ * 20 * 40);
    $display("Timeout: the run did not complete in time");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/lsu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_properties (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               core_req_ready_o,
  input wire logic               bus_req_valid_o,
  input wire lsu_pkg::bus_req_t  bus_req_o,
  input wire logic               bus_gnt_i,
  input wire logic               bus_rvalid_i,
  input wire logic               core_resp_valid_o
);

  import lsu_pkg::*;

  // Granted and not yet answered
  logic [2:0] outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(bus_req_valid_o && bus_gnt_i) - 3'(bus_rvalid_i);
    end
  end

  // Request held until grant
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o && !bus_gnt_i |=> bus_req_valid_o && $stable(bus_req_o))
    else $error("bus request changed before grant");

  a_max_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= 3'(LSU_MAX_OUTSTANDING))
    else $error("too many outstanding bus transactions");

  a_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
    core_resp_valid_o |-> outstanding_q != 3'd0)
    else $error("core response with nothing outstanding");

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !core_req_ready_o && !bus_req_valid_o && !core_resp_valid_o)
    else $error("control output high during reset");

endmodule

bind lsu_top lsu_properties u_properties (
  .clk               (clk),
  .rst_n             (rst_n),
  .core_req_ready_o  (core_req_ready_o),
  .bus_req_valid_o   (bus_req_valid_o),
  .bus_req_o         (bus_req_o),
  .bus_gnt_i         (bus_gnt_i),
  .bus_rvalid_i      (bus_rvalid_i),
  .core_resp_valid_o (core_resp_valid_o)
);

`default_nettype wire

// ==== sim/lsu_bus_responder.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_responder (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                bus_req_valid_i,
  input  wire lsu_pkg::bus_req_t   bus_req_i,
  output logic                     bus_gnt_o,
  output logic                     bus_rvalid_o,
  output lsu_pkg::bus_resp_t       bus_resp_o
);

  import lsu_pkg::*;

  logic [31:0] mem [64];
  // Error flag of every granted transaction, in grant order
  bit          err_log [$];

  // Responses waiting for their due cycle
  bus_resp_t   resp_q [$];
  int          due_q [$];

  integer      seed;
  int          cyc;
  int          gnt_wait;
  int          last_due;

  initial begin
    seed = 32'hbe7;
    cyc = 0;
    gnt_wait = 0;
    last_due = 0;
    bus_gnt_o = 1'b0;
    bus_rvalid_o = 1'b0;
    bus_resp_o = '0;
    // Fill pattern mixes the whole word index
    for (int i = 0; i < 64; i++) begin
      mem[i] = (32'h9e3779b9 * (i + 1)) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5a};
    end
  end

  always begin
    logic [31:0] r;
    logic [5:0]  idx;
    bus_resp_t   resp;
    int          due;
    // Sample the handshake mid-cycle, where it is stable
    @(negedge clk);
    if (rst_n && bus_req_valid_i && bus_gnt_o) begin
      idx = bus_req_i.addr[7:2];
      resp.rdata = bus_req_i.we ? 32'h0 : mem[idx];
      if (bus_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_req_i.be[b]) mem[idx][8*b +: 8] = bus_req_i.wdata[8*b +: 8];
        end
      end
      r = $random(seed);
      resp.err = (r[2:0] == 3'b000);
      err_log.push_back(resp.err);
      // In order, 1 to 4 cycles after the grant
      r = $random(seed);
      due = cyc + 1 + int'(r[1:0]);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      resp_q.push_back(resp);
      due_q.push_back(due);
      r = $random(seed);
      gnt_wait = int'(r[1:0]);
    end else if (gnt_wait > 0) begin
      gnt_wait--;
    end
    @(posedge clk);
    #1;
    cyc++;
    bus_gnt_o = rst_n && (gnt_wait == 0);
    bus_rvalid_o = 1'b0;
    bus_resp_o = '0;
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      void'(due_q.pop_front());
      bus_resp_o = resp_q.pop_front();
      bus_rvalid_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // Core request
  input  wire logic                core_req_valid_i,
  input  wire lsu_pkg::lsu_req_t   core_req_i,
  output logic                     core_req_ready_o,
  // Bus request
  output logic                     bus_req_valid_o,
  output lsu_pkg::bus_req_t        bus_req_o,
  input  wire logic                bus_gnt_i,
  // Bus response
  input  wire logic                bus_rvalid_i,
  input  wire lsu_pkg::bus_resp_t  bus_resp_i,
  // Core response
  output logic                     core_resp_valid_o,
  output lsu_pkg::lsu_resp_t       core_resp_o
);

  import lsu_pkg::*;

  // Producer to buffer
  logic      push;
  logic      push_ready;
  lsu_ctrl_t push_ctrl;

  // Buffer to consumer
  lsu_ctrl_t head_ctrl;

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  lsu_request_gen u_request_gen (
    .clk              (clk),
    .rst_n            (rst_n),
    .core_req_valid_i (core_req_valid_i),
    .core_req_i       (core_req_i),
    .core_req_ready_o (core_req_ready_o),
    .bus_req_valid_o  (bus_req_valid_o),
    .bus_req_o        (bus_req_o),
    .bus_gnt_i        (bus_gnt_i),
    .push_ready_i     (push_ready),
    .push_o           (push),
    .push_ctrl_o      (push_ctrl)
  );

  // Occupancy is the count of outstanding transactions
  lsu_ctrl_fifo u_ctrl_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (push),
    .push_ctrl_i  (push_ctrl),
    .push_ready_o (push_ready),
    .pop_i        (bus_rvalid_i),
    .head_ctrl_o  (head_ctrl)
  );

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk               (clk),
    .rst_n             (rst_n),
    .bus_rvalid_i      (bus_rvalid_i),
    .bus_resp_i        (bus_resp_i),
    .head_ctrl_i       (head_ctrl),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o)
  );

endmodule

`default_nettype wire

// ==== hw/lsu_rdata_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // Bus response side
  input  wire logic                bus_rvalid_i,
  input  wire lsu_pkg::bus_resp_t  bus_resp_i,
  // Control entry of the answered transaction
  input  wire lsu_pkg::lsu_ctrl_t  head_ctrl_i,
  // Core response side
  output logic                     core_resp_valid_o,
  output lsu_pkg::lsu_resp_t       core_resp_o
);

  import lsu_pkg::*;

  logic [LSU_DATA_W-1:0]   rdata_q;    // First-part read word
  logic                    err_q;      // First-part error
  logic                    first_part;
  logic                    is_split;
  logic [2*LSU_DATA_W-1:0] rdata_full;
  logic [2*LSU_DATA_W-1:0] rdata_aligned;
  logic [LSU_DATA_W-1:0]   rdata_ext;

  assign first_part = bus_rvalid_i && !head_ctrl_i.last;

  // Same rule as the split decision on the request side
  always_comb begin
    case (head_ctrl_i.size)
      LSU_SIZE_HALF: is_split = (head_ctrl_i.offset == 2'b11);
      LSU_SIZE_BYTE: is_split = 1'b0;
      default:       is_split = (head_ctrl_i.offset != 2'b00);
    endcase
  end

  ////////////////////////////////////////////////////////////
  // First-part capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (first_part) begin
      rdata_q <= bus_resp_i.rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (first_part) begin
      err_q <= bus_resp_i.err;
    end
  end

  ////////////////////////////////////////////////////////////
  // Realign and extend
  ////////////////////////////////////////////////////////////

  // New word above the stored one, or duplicated when unsplit
  assign rdata_full = is_split ? {bus_resp_i.rdata, rdata_q}
                               : {bus_resp_i.rdata, bus_resp_i.rdata};

  assign rdata_aligned = rdata_full >> {head_ctrl_i.offset, 3'b000};

  always_comb begin
    case (head_ctrl_i.size)
      LSU_SIZE_BYTE: begin
        rdata_ext = {{24{head_ctrl_i.sext && rdata_aligned[7]}}, rdata_aligned[7:0]};
      end
      LSU_SIZE_HALF: begin
        rdata_ext = {{16{head_ctrl_i.sext && rdata_aligned[15]}}, rdata_aligned[15:0]};
      end
      default: begin
        rdata_ext = rdata_aligned[LSU_DATA_W-1:0];
      end
    endcase
  end

  // One response per core request, on its last part
  assign core_resp_valid_o = bus_rvalid_i && head_ctrl_i.last;

  always_comb begin
    // Stores answer with zero data
    core_resp_o.rdata = head_ctrl_i.we ? '0 : rdata_ext;
    // Errors of both parts are merged
    core_resp_o.err   = bus_resp_i.err || (is_split && err_q);
  end

endmodule

`default_nettype wire

// ==== hw/lsu_ctrl_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fifo (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // Push on every bus grant
  input  wire logic                push_i,
  input  wire lsu_pkg::lsu_ctrl_t  push_ctrl_i,
  output logic                     push_ready_o,
  // Pop on every bus response
  input  wire logic                pop_i,
  output lsu_pkg::lsu_ctrl_t       head_ctrl_o
);

  import lsu_pkg::*;

  // Entries in flight
  lsu_ctrl_t            mem [LSU_MAX_OUTSTANDING];
  logic                 wr_ptr_q;
  logic                 rd_ptr_q;
  logic [LSU_CNT_W-1:0] cnt_q;
  logic                 full;

  assign full = (cnt_q == LSU_CNT_W'(LSU_MAX_OUTSTANDING));

  // A response in the same cycle frees a slot
  assign push_ready_o = !full || pop_i;

  assign head_ctrl_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_ctrl_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      // Up on push, down on pop, unchanged on both
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsu_request_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_request_gen (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // Core request side
  input  wire logic               core_req_valid_i,
  input  wire lsu_pkg::lsu_req_t  core_req_i,
  output logic                    core_req_ready_o,
  // Bus request side
  output logic                    bus_req_valid_o,
  output lsu_pkg::bus_req_t       bus_req_o,
  input  wire logic               bus_gnt_i,
  // Control FIFO push side
  input  wire logic               push_ready_i,
  output logic                    push_o,
  output lsu_pkg::lsu_ctrl_t      push_ctrl_o
);

  import lsu_pkg::*;

  logic                  split_q;     // Second part of a split is pending
  logic                  need_split;  // Current request needs a second part
  logic                  gnt;
  logic [1:0]            offset;
  logic [LSU_ADDR_W-1:0] word_addr;
  logic [LSU_BE_W-1:0]   size_mask;
  logic [2*LSU_BE_W-1:0] be_wide;
  logic [2*LSU_DATA_W-1:0] wdata_wide;

  assign offset    = core_req_i.addr[1:0];
  assign word_addr = {core_req_i.addr[LSU_ADDR_W-1:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////////////////////////

  // Words off alignment and halfwords at offset 3 cross a word
  always_comb begin
    need_split = 1'b0;
    if (!split_q) begin
      case (core_req_i.size)
        LSU_SIZE_HALF: need_split = (offset == 2'b11);
        LSU_SIZE_BYTE: need_split = 1'b0;
        default:       need_split = (offset != 2'b00);
      endcase
    end
  end

  // Valid follows core valid, held off while the FIFO is full
  assign bus_req_valid_o = core_req_valid_i && push_ready_i;
  assign gnt             = bus_req_valid_o && bus_gnt_i;

  // Core is released only on grant of the last part
  assign core_req_ready_o = gnt && !need_split;

  // Set on first-part grant, cleared on second-part grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (gnt) begin
      split_q <= need_split;
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte enables and write data
  ////////////////////////////////////////////////////////////

  // Lanes covered by the access before shifting
  always_comb begin
    case (core_req_i.size)
      LSU_SIZE_BYTE: size_mask = 4'b0001;
      LSU_SIZE_HALF: size_mask = 4'b0011;
      default:       size_mask = 4'b1111;
    endcase
  end

  // Low half is the first word, high half spills into the next
  assign be_wide = {{LSU_BE_W{1'b0}}, size_mask} << offset;

  // Rotate left by whole bytes, same data for both parts
  assign wdata_wide = {core_req_i.wdata, core_req_i.wdata} << {offset, 3'b000};

  always_comb begin
    bus_req_o.we    = core_req_i.we;
    bus_req_o.wdata = wdata_wide[2*LSU_DATA_W-1:LSU_DATA_W];
    if (split_q) begin
      // Next word, remaining lanes from bit 0 up
      bus_req_o.addr = word_addr + LSU_ADDR_W'(4);
      bus_req_o.be   = be_wide[2*LSU_BE_W-1:LSU_BE_W];
    end else begin
      bus_req_o.addr = word_addr;
      bus_req_o.be   = be_wide[LSU_BE_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Control entry for the response path
  ////////////////////////////////////////////////////////////

  assign push_o = gnt;

  always_comb begin
    push_ctrl_o.size   = core_req_i.size;
    push_ctrl_o.sext   = core_req_i.sext;
    push_ctrl_o.we     = core_req_i.we;
    push_ctrl_o.offset = offset;
    push_ctrl_o.last   = !need_split;
  end

endmodule

`default_nettype wire

// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////////////////////////

  // Byte address and data word
  localparam int unsigned LSU_ADDR_W = 32;
  localparam int unsigned LSU_DATA_W = 32;

  // One enable per byte lane
  localparam int unsigned LSU_BE_W = 4;

  // Granted bus transactions still waiting for a response
  localparam int unsigned LSU_MAX_OUTSTANDING = 2;

  // Must hold 0..LSU_MAX_OUTSTANDING
  localparam int unsigned LSU_CNT_W = 2;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // Access size, encoding as on the core side
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

  // Core request, byte address and unrotated write data
  typedef struct packed {
    logic [LSU_ADDR_W-1:0] addr;
    logic                  we;
    lsu_size_e             size;
    logic                  sext;
    logic [LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  // Core response, one per accepted request
  typedef struct packed {
    logic [LSU_DATA_W-1:0] rdata;
    logic                  err;
  } lsu_resp_t;

  // Bus request, address always word aligned
  typedef struct packed {
    logic [LSU_ADDR_W-1:0] addr;
    logic                  we;
    logic [LSU_BE_W-1:0]   be;
    logic [LSU_DATA_W-1:0] wdata;
  } bus_req_t;

  // Bus response, no ready on this channel
  typedef struct packed {
    logic [LSU_DATA_W-1:0] rdata;
    logic                  err;
  } bus_resp_t;

  // Kept per transaction from grant until its response
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    logic       last;    // low only for first part of a split
  } lsu_ctrl_t;

endpackage

`default_nettype wire
